// ==== aes_cim_top.f ====
logic/aes_pkg.sv
logic/cim_pkg.sv
logic/round_transform.sv
logic/round_sequencer.sv
logic/state_store.sv
logic/ark_capture.sv
logic/array_addresser.sv
logic/aes_cim_top.sv
tb/cim_array_model.sv
tb/aes_cim_tb.sv

// ==== tb/aes_cim_tb.sv ====
// testbench with clock, reset, stimulus, reference function, compare tasks and timeout
`timescale 1ns/100ps
module aes_cim_tb
    import aes_pkg::*, cim_pkg::*;
();

    localparam int clk_period     = 100;
    localparam int num_blocks     = 3;
    localparam int block_limit    = 1300;
    localparam int timeout_cycles = 4000;

    logic       CLK;
    logic       rst;
    aes_state_t din;
    logic       kd_rdy;
    logic       rd_done;
    rio_bus_t   rio;
    aes_state_t dout;
    logic       k_vld;
    logic       d_vld;
    logic       bsy;
    logic       sel_ad0;
    slice_t     in_slice;
    demux_bus_t demux_add;
    row_bus_t   rwl_dec_add;

    logic [0:num_groups-1][127:0] keys;
    logic [0:num_groups-1][127:0] src_states;
    aes_state_t expected;
    integer     seed = 19322;
    int         mismatches = 0;
    int         other_errors = 0;
    int         cycle_cnt = 0;
    int         strobe_cnt = 0;
    int         lookup_cnt = 0;
    logic       lookup_due = 1'b0;
    logic       running = 1'b0;
    logic       done_seen = 1'b0;

    aes_cim_top UUT (
        .CLK         (CLK),
        .rst         (rst),
        .din         (din),
        .kd_rdy      (kd_rdy),
        .rd_done     (rd_done),
        .rio         (rio),
        .dout        (dout),
        .k_vld       (k_vld),
        .d_vld       (d_vld),
        .bsy         (bsy),
        .sel_ad0     (sel_ad0),
        .in_slice    (in_slice),
        .demux_add   (demux_add),
        .rwl_dec_add (rwl_dec_add)
    );

    cim_array_model #(.seed_init(19322)) array_model (
        .CLK         (CLK),
        .rst         (rst),
        .bsy         (bsy),
        .sel_ad0     (sel_ad0),
        .in_slice    (in_slice),
        .demux_add   (demux_add),
        .rwl_dec_add (rwl_dec_add),
        .round_keys  (keys),
        .rd_done     (rd_done),
        .rio         (rio)
    );

    initial begin
        CLK = 1'b0;
        forever #(clk_period / 2) CLK = ~CLK;
    end

    // --------------------------------------------------
    // reference cipher flow
    // --------------------------------------------------
    function automatic logic [7:0] lookup_value(input logic [7:0] x);
        logic [7:0] y;
        y = x + {x[5:0], 2'b00} + 8'h63;
        return y;
    endfunction

    function automatic logic [7:0] gf_double(input logic [7:0] x);
        return {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
    endfunction

    // column-major state, row r rotates left by r
    function automatic aes_state_t shift_rows(input aes_state_t s);
        aes_state_t t;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                t[r + 4 * c] = s[r + 4 * ((c + r) % 4)];
            end
        end
        return t;
    endfunction

    function automatic aes_state_t mix_columns(input aes_state_t s);
        aes_state_t      t;
        logic [0:3][7:0] a;
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                a[r] = s[4 * c + r];
            end
            // 2*a[r] ^ 3*a[r+1] ^ a[r+2] ^ a[r+3]
            for (int r = 0; r < 4; r++) begin
                t[4 * c + r] = gf_double(a[r]) ^ gf_double(a[(r + 1) % 4])
                    ^ a[(r + 1) % 4] ^ a[(r + 2) % 4] ^ a[(r + 3) % 4];
            end
        end
        return t;
    endfunction

    function automatic aes_state_t aes_cim_ref(input aes_state_t pt,
                                               output logic [0:num_groups-1][127:0] src);
        aes_state_t st;
        aes_state_t sub;
        st = pt;
        for (int r = 0; r < last_group; r++) begin
            src[r] = st;
            sub    = st ^ keys[r];
            for (int b = 0; b < state_bytes; b++) begin
                sub[b] = lookup_value(sub[b]);
            end
            st = (r == last_group - 1) ? shift_rows(sub) : mix_columns(shift_rows(sub));
        end
        src[last_group] = st;
        return st ^ keys[last_group];
    endfunction

    // --------------------------------------------------
    // compare tasks
    // --------------------------------------------------
    task automatic check_state(input aes_state_t got, input aes_state_t exp, input string msg);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_slice(input slice_t got, input slice_t exp, input string msg);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_addr(input demux_addr_t got_d, input row_addr_t got_r,
                              input demux_addr_t exp_d, input row_addr_t exp_r,
                              input string msg);
        if (got_d !== exp_d || got_r !== exp_r) begin
            $display("Mismatch at %0t: %s got %0d/%0d expected %0d/%0d",
                     $time, msg, got_d, got_r, exp_d, exp_r);
            mismatches++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string msg);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, msg, got, exp);
            mismatches++;
        end
    endtask

    // --------------------------------------------------
    // run monitor, sampled mid-cycle
    // --------------------------------------------------
    always @(negedge CLK) begin
        int         g;
        int         i;
        int         demux_code;
        int         row_code;
        slice_t     exp_slice;
        aes_state_t x;
        if (running) begin
            if (sel_ad0) begin
                g          = strobe_cnt / slices_per_group;
                i          = strobe_cnt % slices_per_group;
                exp_slice  = src_states[g][127 - 16 * i -: 16];
                check_slice(in_slice, exp_slice, $sformatf("in_slice group %0d slice %0d", g, i));
                demux_code = 7 - (g % 4);
                row_code   = g / 4;
                for (int b = 0; b < state_bytes; b++) begin
                    check_addr(demux_add[b], rwl_dec_add[b], demux_code[2:0], row_code[5:0],
                               $sformatf("read address byte %0d group %0d", b, g));
                end
                strobe_cnt++;
                // groups 0 to 9 end in a lookup
                if (i == slices_per_group - 1 && g < last_group) begin
                    lookup_due = 1'b1;
                end
            end else begin
                check_slice(in_slice, '0, "in_slice outside a strobe");
                if (rd_done && lookup_due) begin
                    g = strobe_cnt / slices_per_group - 1;
                    x = src_states[g] ^ keys[g];
                    for (int b = 0; b < state_bytes; b++) begin
                        check_addr(demux_add[b], rwl_dec_add[b], {1'b0, x[b][7:6]}, x[b][5:0],
                                   $sformatf("lookup address byte %0d group %0d", b, g));
                    end
                    lookup_due = 1'b0;
                    lookup_cnt++;
                end
            end
            if (d_vld) begin
                check_flag(bsy, 1'b0, "bsy with d_vld");
                check_state(dout, expected, "dout on d_vld");
                if (strobe_cnt != num_groups * slices_per_group || lookup_cnt != last_group) begin
                    $display("wrong run length: %0d read strobes and %0d lookups",
                             strobe_cnt, lookup_cnt);
                    other_errors++;
                end
                done_seen = 1'b1;
            end else begin
                check_flag(bsy, 1'b1, "bsy during run");
            end
        end
    end

    // hard stop
    always @(posedge CLK) begin
        cycle_cnt++;
        if (cycle_cnt >= timeout_cycles) begin
            $display("timeout: run stopped after %0d cycles", cycle_cnt);
            $display("error count: %0d mismatches, %0d other errors", mismatches, other_errors);
            $display("tests failed");
            $finish;
        end
    end

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    initial begin
        aes_state_t pt;
        int         waited;
        rst    = 1'b1;
        kd_rdy = 1'b0;
        din    = '0;
        for (int r = 0; r < num_groups; r++) begin
            keys[r] = {$random(seed), $random(seed), $random(seed), $random(seed)};
        end
        repeat (4) @(posedge CLK);
        rst <= 1'b0;
        @(negedge CLK);
        check_flag(bsy, 1'b0, "bsy after reset");
        check_flag(k_vld, 1'b0, "k_vld after reset");
        check_flag(d_vld, 1'b0, "d_vld after reset");
        check_flag(sel_ad0, 1'b0, "sel_ad0 after reset");
        check_slice(in_slice, '0, "in_slice after reset");
        check_state(dout, '0, "dout after reset");
        for (int b = 0; b < state_bytes; b++) begin
            check_addr(demux_add[b], rwl_dec_add[b], '0, '0, "address after reset");
        end
        for (int blk = 0; blk < num_blocks; blk++) begin
            if (blk == 0) begin
                pt = '0;
            end else begin
                pt = {$random(seed), $random(seed), $random(seed), $random(seed)};
            end
            expected = aes_cim_ref(pt, src_states);
            @(posedge CLK);
            din    <= pt;
            kd_rdy <= 1'b1;
            @(posedge CLK);
            kd_rdy     <= 1'b0;
            strobe_cnt = 0;
            lookup_cnt = 0;
            lookup_due = 1'b0;
            done_seen  = 1'b0;
            running    = 1'b1;
            @(negedge CLK);
            check_flag(k_vld, 1'b1, "k_vld after start");
            @(negedge CLK);
            check_flag(k_vld, 1'b0, "k_vld one cycle later");
            if (blk == 1) begin
                // second start with other data while busy
                @(posedge CLK);
                din    <= ~pt;
                kd_rdy <= 1'b1;
                @(posedge CLK);
                kd_rdy <= 1'b0;
                @(negedge CLK);
                check_flag(k_vld, 1'b0, "k_vld after kd_rdy while busy");
            end
            waited = 0;
            while (!done_seen && waited < block_limit) begin
                @(posedge CLK);
                waited++;
            end
            running = 1'b0;
            if (!done_seen) begin
                $display("no d_vld within %0d cycles for block %0d", block_limit, blk);
                other_errors++;
            end
            @(negedge CLK);
            check_flag(d_vld, 1'b0, "d_vld after one cycle");
            check_state(dout, expected, "dout held after d_vld");
        end
        $display("error count: %0d mismatches, %0d other errors", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== tb/cim_array_model.sv ====
// behavioural memory array with round keys, lookup table, bit-plane answers and rd_done pacing
`timescale 1ns/100ps
module cim_array_model
    import aes_pkg::*, cim_pkg::*;
#(
    parameter int seed_init = 19322
) (
    input  logic                         CLK,
    input  logic                         rst,
    input  logic                         bsy,
    input  logic                         sel_ad0,
    input  slice_t                       in_slice,
    input  demux_bus_t                   demux_add,
    input  row_bus_t                     rwl_dec_add,
    input  logic [0:num_groups-1][127:0] round_keys,
    output logic                         rd_done,
    output rio_bus_t                     rio
);

    integer     seed = seed_init;
    int         gap;
    slice_idx_t slice_cnt;
    logic       pulse_q = 1'b0;
    rio_bus_t   rio_q = '0;

    assign rd_done = pulse_q;
    assign rio     = rio_q;

    // stand-in for the s-box, 5x + 0x63 mod 256
    function automatic logic [7:0] table_value(input logic [7:0] x);
        logic [7:0] y;
        y = x + {x[5:0], 2'b00} + 8'h63;
        return y;
    endfunction

    // --------------------------------------------------
    // array response and strobe pacing
    // --------------------------------------------------
    always @(posedge CLK or posedge rst) begin
        int         g;
        aes_state_t key;
        logic [7:0] x_even;
        logic [7:0] x_odd;
        rio_bus_t   plane;
        if (rst) begin
            pulse_q   <= 1'b0;
            rio_q     <= '0;
            gap       <= 2;
            slice_cnt <= '0;
        end else begin
            if (sel_ad0) begin
                // four groups per row, demux counts down from 7
                g      = 4 * rwl_dec_add[0] + (7 - demux_add[0]);
                key    = round_keys[g];
                x_even = in_slice[15:8] ^ key[2 * slice_cnt];
                x_odd  = in_slice[7:0] ^ key[2 * slice_cnt + 1];
                plane  = '0;
                for (int m = 0; m < 8; m++) begin
                    plane[m][7 - slice_cnt]     = x_even[m];
                    plane[8 + m][7 - slice_cnt] = x_odd[m];
                end
                rio_q     <= plane;
                slice_cnt <= slice_cnt + 1'b1;
            end else if (!demux_add[0][2]) begin
                // table lookup, address is {demux[1:0], row}
                for (int b = 0; b < state_bytes; b++) begin
                    plane[b] = table_value({demux_add[b][1:0], rwl_dec_add[b]});
                end
                rio_q <= plane;
            end
            // 3 to 5 quiet cycles between pulses
            if (bsy && gap == 0) begin
                pulse_q <= 1'b1;
                gap     <= 3 + {$random(seed)} % 3;
            end else begin
                pulse_q <= 1'b0;
                if (gap > 0) begin
                    gap <= gap - 1;
                end
            end
        end
    end

endmodule

// ==== logic/aes_cim_top.sv ====
// controller top level with sequencer, state store, capture and addresser
`timescale 1ns/100ps
module aes_cim_top
    import aes_pkg::*, cim_pkg::*;
(
    input  logic       CLK,
    input  logic       rst,
    input  aes_state_t din,
    input  logic       kd_rdy,
    input  logic       rd_done,
    input  rio_bus_t   rio,
    output aes_state_t dout,
    output logic       k_vld,
    output logic       d_vld,
    output logic       bsy,
    output logic       sel_ad0,
    output slice_t     in_slice,
    output demux_bus_t demux_add,
    output row_bus_t   rwl_dec_add
);

    phase_t     phase;
    group_t     group;
    slice_idx_t slice_idx;
    logic       rd_strobe;
    round_op_t  round_op;
    logic       result_load;
    aes_state_t ark;

    // --------------------------------------------------
    // control
    // --------------------------------------------------
    round_sequencer u_round_sequencer (
        .CLK         (CLK),
        .rst         (rst),
        .kd_rdy      (kd_rdy),
        .rd_done     (rd_done),
        .phase       (phase),
        .group       (group),
        .slice_idx   (slice_idx),
        .rd_strobe   (rd_strobe),
        .sel_ad0     (sel_ad0),
        .round_op    (round_op),
        .result_load (result_load),
        .k_vld       (k_vld),
        .d_vld       (d_vld),
        .bsy         (bsy)
    );

    // --------------------------------------------------
    // datapath
    // --------------------------------------------------
    state_store u_state_store (
        .CLK       (CLK),
        .rst       (rst),
        .kd_rdy    (kd_rdy),
        .phase     (phase),
        .round_op  (round_op),
        .slice_idx (slice_idx),
        .rd_strobe (rd_strobe),
        .din       (din),
        .rio       (rio),
        .in_slice  (in_slice)
    );

    ark_capture u_ark_capture (
        .CLK         (CLK),
        .rst         (rst),
        .rd_strobe   (rd_strobe),
        .slice_idx   (slice_idx),
        .rio         (rio),
        .result_load (result_load),
        .ark         (ark),
        .dout        (dout)
    );

    array_addresser u_array_addresser (
        .phase       (phase),
        .group       (group),
        .rd_strobe   (rd_strobe),
        .ark         (ark),
        .demux_add   (demux_add),
        .rwl_dec_add (rwl_dec_add)
    );

endmodule

// ==== logic/array_addresser.sv ====
// demux and row address generation per phase
`timescale 1ns/100ps
module array_addresser
    import aes_pkg::*, cim_pkg::*;
(
    input  phase_t     phase,
    input  group_t     group,
    input  logic       rd_strobe,
    input  aes_state_t ark,
    output demux_bus_t demux_add,
    output row_bus_t   rwl_dec_add
);

    always_comb begin
        for (int b = 0; b < state_bytes; b++) begin
            if (rd_strobe) begin
                // round key location of this group
                demux_add[b]   = group_demux(group);
                rwl_dec_add[b] = group_row(group);
            end else if (phase == ph_lookup) begin
                // table entry selected by the key-added byte
                demux_add[b]   = {1'b0, ark[b][7:6]};
                rwl_dec_add[b] = ark[b][5:0];
            end else begin
                demux_add[b]   = '0;
                rwl_dec_add[b] = '0;
            end
        end
    end

endmodule

// ==== logic/ark_capture.sv ====
// bit-plane transpose into key-added bytes and the result register
`timescale 1ns/100ps
module ark_capture
    import aes_pkg::*, cim_pkg::*;
(
    input  logic       CLK,
    input  logic       rst,
    input  logic       rd_strobe,
    input  slice_idx_t slice_idx,
    input  rio_bus_t   rio,
    input  logic       result_load,
    output aes_state_t ark,
    output aes_state_t dout
);

    logic       strb_q;
    slice_idx_t idx_q;
    logic [7:0] plane_even;
    logic [7:0] plane_odd;

    // array answers one cycle after the strobe
    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            strb_q <= 1'b0;
            idx_q  <= '0;
        end else begin
            strb_q <= rd_strobe;
            idx_q  <= slice_idx;
        end
    end

    // bit 7-i of every array byte forms the pair of bytes for slice i
    always_comb begin
        for (int m = 0; m < 8; m++) begin
            plane_even[m] = rio[m][3'd7 - idx_q];
            plane_odd[m]  = rio[8 + m][3'd7 - idx_q];
        end
    end

    always_ff @(posedge CLK) begin
        if (strb_q) begin
            ark[{idx_q, 1'b0}] <= plane_even;
            ark[{idx_q, 1'b1}] <= plane_odd;
        end
    end

    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            dout <= '0;
        end else if (result_load) begin
            dout <= ark;
        end
    end

endmodule

// ==== logic/state_store.sv ====
// state register, round transform selection and slice picking
`timescale 1ns/100ps
module state_store
    import aes_pkg::*, cim_pkg::*;
(
    input  logic       CLK,
    input  logic       rst,
    input  logic       kd_rdy,
    input  phase_t     phase,
    input  round_op_t  round_op,
    input  slice_idx_t slice_idx,
    input  logic       rd_strobe,
    input  aes_state_t din,
    input  rio_bus_t   rio,
    output slice_t     in_slice
);

    aes_state_t state_q;
    aes_state_t state_src;

    // plaintext on start, lookup result after each lookup
    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            state_q <= '0;
        end else if ((phase == ph_idle) && kd_rdy) begin
            state_q <= din;
        end else if (phase == ph_mix) begin
            state_q <= rio;
        end
    end

    round_transform u_round_transform (
        .state_in  (state_q),
        .op        (round_op),
        .state_out (state_src)
    );

    // msb-first, two bytes per slice
    assign in_slice = rd_strobe ?
        {state_src[{slice_idx, 1'b0}], state_src[{slice_idx, 1'b1}]} : '0;

endmodule

// ==== logic/round_sequencer.sv ====
// phase machine, group and slice counters, status pulses and busy level
`timescale 1ns/100ps
module round_sequencer
    import aes_pkg::*, cim_pkg::*;
(
    input  logic       CLK,
    input  logic       rst,
    input  logic       kd_rdy,
    input  logic       rd_done,
    output phase_t     phase,
    output group_t     group,
    output slice_idx_t slice_idx,
    output logic       rd_strobe,
    output logic       sel_ad0,
    output round_op_t  round_op,
    output logic       result_load,
    output logic       k_vld,
    output logic       d_vld,
    output logic       bsy
);

    logic last_slice;

    // operation applied to the source state of group g
    function automatic round_op_t op_for(input group_t g);
        if (g == '0) begin
            return op_pass;
        end
        if (g == last_group) begin
            return op_final;
        end
        return op_mix;
    endfunction

    // a strobe only counts while reading
    assign rd_strobe  = (phase == ph_read) && rd_done;
    assign sel_ad0    = rd_strobe;
    assign last_slice = (slice_idx == slices_per_group - 1);

    // --------------------------------------------------
    // phase machine
    // --------------------------------------------------
    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            phase       <= ph_idle;
            group       <= '0;
            slice_idx   <= '0;
            round_op    <= op_pass;
            result_load <= 1'b0;
            k_vld       <= 1'b0;
            d_vld       <= 1'b0;
            bsy         <= 1'b0;
        end else begin
            // single-cycle pulses
            k_vld       <= 1'b0;
            d_vld       <= 1'b0;
            result_load <= 1'b0;
            case (phase)
                ph_idle: begin
                    if (kd_rdy) begin
                        phase     <= ph_read;
                        group     <= '0;
                        slice_idx <= '0;
                        round_op  <= op_pass;
                        k_vld     <= 1'b1;
                        bsy       <= 1'b1;
                    end
                end
                ph_read: begin
                    if (rd_strobe) begin
                        // wraps back to 0 after the eighth slice
                        slice_idx <= slice_idx + 3'd1;
                        if (last_slice) begin
                            phase <= (group == last_group) ? ph_drain : ph_lookup;
                        end
                    end
                end
                ph_lookup: begin
                    if (rd_done) begin
                        phase <= ph_mix;
                    end
                end
                ph_mix: begin
                    group    <= group + 4'd1;
                    round_op <= op_for(group + 4'd1);
                    phase    <= ph_read;
                end
                ph_drain: begin
                    // last capture lands on this edge
                    phase       <= ph_done;
                    result_load <= 1'b1;
                end
                ph_done: begin
                    phase <= ph_idle;
                    d_vld <= 1'b1;
                    bsy   <= 1'b0;
                end
                default: begin
                    phase <= ph_idle;
                end
            endcase
        end
    end

endmodule

// ==== logic/round_transform.sv ====
// aes shiftrows and mixcolumns on a 128-bit state
`timescale 1ns/100ps
module round_transform
    import aes_pkg::*;
(
    input  aes_state_t state_in,
    input  round_op_t  op,
    output aes_state_t state_out
);

    aes_state_t shifted;
    aes_state_t mixed;

    // one column, a0 on top
    function automatic logic [31:0] mix_col(input logic [31:0] col);
        logic [7:0] a0;
        logic [7:0] a1;
        logic [7:0] a2;
        logic [7:0] a3;
        a0 = col[31:24];
        a1 = col[23:16];
        a2 = col[15:8];
        a3 = col[7:0];
        return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
                a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
                a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
                xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
    endfunction

    // row r rotates left by r columns, byte index is 4*col + row
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                shifted[4*c + r] = state_in[4*((c + r) % 4) + r];
            end
        end
    end

    always_comb begin
        for (int c = 0; c < 4; c++) begin
            {mixed[4*c], mixed[4*c + 1], mixed[4*c + 2], mixed[4*c + 3]} =
                mix_col({shifted[4*c], shifted[4*c + 1], shifted[4*c + 2], shifted[4*c + 3]});
        end
    end

    always_comb begin
        case (op)
            op_mix:   state_out = mixed;
            op_final: state_out = shifted;
            default:  state_out = state_in;
        endcase
    end

endmodule

// ==== logic/cim_pkg.sv ====
// memory-array types, slice geometry, the phase enum and group address codes
package cim_pkg;

    // --------------------------------------------------
    // slice geometry
    // --------------------------------------------------
    localparam int slices_per_group = 8;

    typedef logic [15:0] slice_t;
    typedef logic [2:0]  slice_idx_t;

    // --------------------------------------------------
    // array address and data buses
    // --------------------------------------------------
    typedef logic [2:0] demux_addr_t;
    typedef logic [5:0] row_addr_t;

    typedef demux_addr_t [0:15] demux_bus_t;
    typedef row_addr_t   [0:15] row_bus_t;
    typedef logic [0:15][7:0]   rio_bus_t;

    typedef enum logic [2:0] {
        ph_idle,
        ph_read,
        ph_lookup,
        ph_mix,
        ph_drain,
        ph_done
    } phase_t;

    // round key location of a group: four groups share a row
    function automatic demux_addr_t group_demux(input logic [3:0] g);
        return 3'd7 - {1'b0, g[1:0]};
    endfunction

    function automatic row_addr_t group_row(input logic [3:0] g);
        return {4'b0000, g[3:2]};
    endfunction

endpackage

// ==== logic/aes_pkg.sv ====
// cipher types, round counts, the round-operation enum and the xtime helper
package aes_pkg;

    // --------------------------------------------------
    // state geometry and round counts
    // --------------------------------------------------
    localparam int state_bytes = 16;
    localparam int num_groups  = 11;
    localparam int last_group  = num_groups - 1;

    // byte 0 sits in the most significant position
    typedef logic [0:state_bytes-1][7:0] aes_state_t;

    typedef logic [3:0] group_t;

    // pass for group 0, full round for 1..9, shiftrows only for group 10
    typedef enum logic [1:0] {
        op_pass,
        op_mix,
        op_final
    } round_op_t;

    // --------------------------------------------------
    // cipher rules
    // --------------------------------------------------
    // multiply by x in GF(2^8), reduction polynomial 0x11b
    function automatic logic [7:0] xtime(input logic [7:0] x);
        logic [7:0] shifted;
        shifted = {x[6:0], 1'b0};
        return x[7] ? (shifted ^ 8'h1b) : shifted;
    endfunction

endpackage
